//--- lsu_cfg.svh
// LSU configuration with bus widths and word offset size
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_STRB_W 4

// Low address bits that select a byte within a data word
`define LSU_OFFS_W 2

`endif

//--- lsu_pkg.sv
// LSU package with the shared vector types and enums
`include "lsu_cfg.svh"

package lsu_pkg;

  typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;
  typedef logic [`LSU_DATA_W-1:0] lsu_data_t;
  typedef logic [`LSU_STRB_W-1:0] lsu_strb_t;

  // AXI response code
  typedef logic [1:0] lsu_resp_t;

  localparam lsu_resp_t RESP_OKAY   = 2'b00;
  localparam lsu_resp_t RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  // Shared bus arbiter
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_READ  = 2'd1,
    ARB_WRITE = 2'd2,
    ARB_RESP  = 2'd3
  } arb_state_e;

endpackage

//--- lsu_bus_if.sv
// LSU unit bus, single request and single response pulse between a unit and the arbiter
`timescale 1ns/1ps

interface lsu_bus_if;
  import lsu_pkg::*;

  // Request, held until req_ready
  logic      req_valid;
  logic      req_write;
  lsu_addr_t req_addr;
  lsu_data_t req_wdata;
  lsu_strb_t req_wstrb;
  logic      req_ready;

  // One-cycle response, no ready
  logic      resp_valid;
  lsu_data_t resp_data;
  logic      resp_err;

  modport unit (
    output req_valid,
    output req_write,
    output req_addr,
    output req_wdata,
    output req_wstrb,
    input  req_ready,
    input  resp_valid,
    input  resp_data,
    input  resp_err
  );

  modport arbiter (
    input  req_valid,
    input  req_write,
    input  req_addr,
    input  req_wdata,
    input  req_wstrb,
    output req_ready,
    output resp_valid,
    output resp_data,
    output resp_err
  );

endinterface

//--- lsu_load_unit.sv
// LSU load unit, word reads over the shared bus with byte and half extraction
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_load_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               load_valid,
  output logic               load_ready,
  input  lsu_pkg::lsu_addr_t load_addr,
  input  lsu_pkg::lsu_size_e load_size,
  input  logic               load_unsigned,
  output logic               load_resp_valid,
  output lsu_pkg::lsu_data_t load_resp_data,
  output logic               load_resp_err,
  lsu_bus_if.unit            bus
);
  import lsu_pkg::*;

  logic                                  busy;
  logic                                  req_valid_q;
  logic [`LSU_ADDR_W-`LSU_OFFS_W-1:0]    word_q;
  logic [`LSU_OFFS_W-1:0]                offs_q;
  lsu_size_e                             size_q;
  logic                                  unsigned_q;
  logic                                  accept;
  logic                                  misaligned;
  lsu_data_t                             shifted;
  lsu_data_t                             ext_data;

  assign load_ready = !busy;
  assign accept     = load_valid && load_ready;

  always_comb begin
    case (load_size)
      SIZE_HALF: misaligned = load_addr[0];
      SIZE_WORD: misaligned = |load_addr[`LSU_OFFS_W-1:0];
      default:   misaligned = 1'b0;
    endcase
  end

  // Bring the addressed byte or half down to bit 0, then extend
  always_comb begin
    shifted = bus.resp_data >> {offs_q, 3'b000};
    case (size_q)
      SIZE_BYTE: begin
        if (unsigned_q)
          ext_data = {{(`LSU_DATA_W-8){1'b0}}, shifted[7:0]};
        else
          ext_data = {{(`LSU_DATA_W-8){shifted[7]}}, shifted[7:0]};
      end
      SIZE_HALF: begin
        if (unsigned_q)
          ext_data = {{(`LSU_DATA_W-16){1'b0}}, shifted[15:0]};
        else
          ext_data = {{(`LSU_DATA_W-16){shifted[15]}}, shifted[15:0]};
      end
      default: ext_data = bus.resp_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy            <= 1'b0;
      req_valid_q     <= 1'b0;
      load_resp_valid <= 1'b0;
      load_resp_err   <= 1'b0;
    end else begin
      load_resp_valid <= 1'b0;
      if (accept) begin
        if (misaligned) begin
          // Answered locally, nothing goes to the bus
          load_resp_valid <= 1'b1;
          load_resp_err   <= 1'b1;
        end else begin
          busy        <= 1'b1;
          req_valid_q <= 1'b1;
        end
      end
      if (bus.req_valid && bus.req_ready)
        req_valid_q <= 1'b0;
      if (bus.resp_valid && busy) begin
        busy            <= 1'b0;
        load_resp_valid <= 1'b1;
        load_resp_err   <= bus.resp_err;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      word_q     <= load_addr[`LSU_ADDR_W-1:`LSU_OFFS_W];
      offs_q     <= load_addr[`LSU_OFFS_W-1:0];
      size_q     <= load_size;
      unsigned_q <= load_unsigned;
    end
    if (bus.resp_valid && busy)
      load_resp_data <= ext_data;
  end

  assign bus.req_valid = req_valid_q;
  assign bus.req_write = 1'b0;
  assign bus.req_addr  = {word_q, {`LSU_OFFS_W{1'b0}}};
  assign bus.req_wdata = '0;
  assign bus.req_wstrb = '0;

  a_no_req_when_idle: assert property (
    @(posedge clk) disable iff (reset) !busy |-> !bus.req_valid
  ) else $error("load unit requests the bus while idle");

endmodule

//--- lsu_store_unit.sv
// LSU store unit, lane aligned word writes with byte strobes over the shared bus
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_store_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               store_valid,
  output logic               store_ready,
  input  lsu_pkg::lsu_addr_t store_addr,
  input  lsu_pkg::lsu_size_e store_size,
  input  lsu_pkg::lsu_data_t store_data,
  output logic               store_done,
  output logic               store_err,
  lsu_bus_if.unit            bus
);
  import lsu_pkg::*;

  logic                                  busy;
  logic                                  req_valid_q;
  logic [`LSU_ADDR_W-`LSU_OFFS_W-1:0]    word_q;
  lsu_data_t                             wdata_q;
  lsu_strb_t                             wstrb_q;
  logic                                  accept;
  logic                                  misaligned;
  lsu_data_t                             wdata_al;
  lsu_strb_t                             wstrb_al;
  logic [`LSU_OFFS_W-1:0]                offs;

  assign store_ready = !busy;
  assign accept      = store_valid && store_ready;
  assign offs        = store_addr[`LSU_OFFS_W-1:0];

  // Copy the low byte or half into every lane, strobe picks the lane
  always_comb begin
    case (store_size)
      SIZE_HALF: begin
        misaligned = offs[0];
        wdata_al   = {(`LSU_DATA_W/16){store_data[15:0]}};
        wstrb_al   = lsu_strb_t'(2'b11) << offs;
      end
      SIZE_WORD: begin
        misaligned = |offs;
        wdata_al   = store_data;
        wstrb_al   = '1;
      end
      default: begin
        misaligned = 1'b0;
        wdata_al   = {(`LSU_DATA_W/8){store_data[7:0]}};
        wstrb_al   = lsu_strb_t'(1'b1) << offs;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy        <= 1'b0;
      req_valid_q <= 1'b0;
      store_done  <= 1'b0;
      store_err   <= 1'b0;
    end else begin
      store_done <= 1'b0;
      if (accept) begin
        if (misaligned) begin
          store_done <= 1'b1;
          store_err  <= 1'b1;
        end else begin
          busy        <= 1'b1;
          req_valid_q <= 1'b1;
        end
      end
      if (bus.req_valid && bus.req_ready)
        req_valid_q <= 1'b0;
      if (bus.resp_valid && busy) begin
        busy       <= 1'b0;
        store_done <= 1'b1;
        store_err  <= bus.resp_err;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      word_q  <= store_addr[`LSU_ADDR_W-1:`LSU_OFFS_W];
      wdata_q <= wdata_al;
      wstrb_q <= wstrb_al;
    end
  end

  assign bus.req_valid = req_valid_q;
  assign bus.req_write = 1'b1;
  assign bus.req_addr  = {word_q, {`LSU_OFFS_W{1'b0}}};
  assign bus.req_wdata = wdata_q;
  assign bus.req_wstrb = wstrb_q;

  a_strb_nonzero: assert property (
    @(posedge clk) disable iff (reset) bus.req_valid |-> bus.req_wstrb != '0
  ) else $error("store request with empty strobe");

endmodule

//--- lsu_bus_arbiter.sv
// LSU bus arbiter, round-robin between load and store units onto AXI read and write
`timescale 1ns/1ps

module lsu_bus_arbiter (
  input  logic               clk,
  input  logic               reset,
  lsu_bus_if.arbiter         load_bus,
  lsu_bus_if.arbiter         store_bus,
  output lsu_pkg::lsu_addr_t araddr,
  output logic               arvalid,
  input  logic               arready,
  input  lsu_pkg::lsu_data_t rdata,
  input  lsu_pkg::lsu_resp_t rresp,
  input  logic               rvalid,
  output logic               rready,
  output lsu_pkg::lsu_addr_t awaddr,
  output logic               awvalid,
  input  logic               awready,
  output lsu_pkg::lsu_data_t wdata,
  output lsu_pkg::lsu_strb_t wstrb,
  output logic               wvalid,
  input  logic               wready,
  input  lsu_pkg::lsu_resp_t bresp,
  input  logic               bvalid,
  output logic               bready,
  output logic               rack,
  output logic               wack
);
  import lsu_pkg::*;

  arb_state_e state;
  logic       last_store;   // last grant went to the store unit
  logic       sel_store;
  logic       write_q;
  lsu_addr_t  addr_q;
  lsu_data_t  wdata_q;
  lsu_strb_t  wstrb_q;
  logic       ar_done;
  logic       aw_done;
  logic       w_done;
  lsu_data_t  resp_data_q;
  logic       resp_err_q;
  logic       grant;
  logic       pick_store;

  assign grant = (state == ARB_IDLE) && (load_bus.req_valid || store_bus.req_valid);

  // Store wins if alone, or if the load unit won last time
  assign pick_store = store_bus.req_valid && (!load_bus.req_valid || !last_store);

  assign load_bus.req_ready  = grant && !pick_store;
  assign store_bus.req_ready = grant && pick_store;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ARB_IDLE;
      last_store <= 1'b0;
      sel_store  <= 1'b0;
      ar_done    <= 1'b0;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (grant) begin
            sel_store  <= pick_store;
            last_store <= pick_store;
            ar_done    <= 1'b0;
            aw_done    <= 1'b0;
            w_done     <= 1'b0;
            if (pick_store ? store_bus.req_write : load_bus.req_write)
              state <= ARB_WRITE;
            else
              state <= ARB_READ;
          end
        end
        ARB_READ: begin
          if (arvalid && arready)
            ar_done <= 1'b1;
          if (rvalid && rready)
            state <= ARB_RESP;
        end
        ARB_WRITE: begin
          if (awvalid && awready)
            aw_done <= 1'b1;
          if (wvalid && wready)
            w_done <= 1'b1;
          if (bvalid && bready)
            state <= ARB_RESP;
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // Latched request and response payload
  always_ff @(posedge clk) begin
    if (grant) begin
      if (pick_store) begin
        write_q <= store_bus.req_write;
        addr_q  <= store_bus.req_addr;
        wdata_q <= store_bus.req_wdata;
        wstrb_q <= store_bus.req_wstrb;
      end else begin
        write_q <= load_bus.req_write;
        addr_q  <= load_bus.req_addr;
        wdata_q <= load_bus.req_wdata;
        wstrb_q <= load_bus.req_wstrb;
      end
    end
    if (rvalid && rready) begin
      resp_data_q <= rdata;
      resp_err_q  <= rresp != RESP_OKAY;
    end else if (bvalid && bready) begin
      resp_data_q <= '0;
      resp_err_q  <= bresp != RESP_OKAY;
    end
  end

  assign araddr  = addr_q;
  assign arvalid = (state == ARB_READ) && !ar_done;
  assign rready  = state == ARB_READ;

  assign awaddr  = addr_q;
  assign wdata   = wdata_q;
  assign wstrb   = wstrb_q;
  assign awvalid = (state == ARB_WRITE) && !aw_done;
  assign wvalid  = (state == ARB_WRITE) && !w_done;
  assign bready  = state == ARB_WRITE;

  assign rack = (state == ARB_RESP) && !write_q;
  assign wack = (state == ARB_RESP) && write_q;

  assign load_bus.resp_valid  = (state == ARB_RESP) && !sel_store;
  assign store_bus.resp_valid = (state == ARB_RESP) && sel_store;
  assign load_bus.resp_data   = resp_data_q;
  assign store_bus.resp_data  = resp_data_q;
  assign load_bus.resp_err    = resp_err_q;
  assign store_bus.resp_err   = resp_err_q;

  a_ar_hold: assert property (
    @(posedge clk) disable iff (reset) arvalid && !arready |=> arvalid && $stable(araddr)
  ) else $error("arvalid dropped before arready");

  a_no_write_in_read: assert property (
    @(posedge clk) disable iff (reset) state == ARB_READ |-> !awvalid && !wvalid
  ) else $error("write channel active during a read");

  a_one_resp: assert property (
    @(posedge clk) disable iff (reset) !(load_bus.resp_valid && store_bus.resp_valid)
  ) else $error("response sent to both units");

endmodule

//--- lsu_wrap.sv
// LSU top level, load and store units sharing one AXI-style port
`timescale 1ns/1ps

module lsu_wrap (
  input  logic               clk,
  input  logic               reset,

  // Core load side
  input  logic               load_valid,
  output logic               load_ready,
  input  lsu_pkg::lsu_addr_t load_addr,
  input  lsu_pkg::lsu_size_e load_size,
  input  logic               load_unsigned,
  output logic               load_resp_valid,
  output lsu_pkg::lsu_data_t load_resp_data,
  output logic               load_resp_err,

  // Core store side
  input  logic               store_valid,
  output logic               store_ready,
  input  lsu_pkg::lsu_addr_t store_addr,
  input  lsu_pkg::lsu_size_e store_size,
  input  lsu_pkg::lsu_data_t store_data,
  output logic               store_done,
  output logic               store_err,

  // AR and R
  output lsu_pkg::lsu_addr_t araddr,
  output logic               arvalid,
  input  logic               arready,
  input  lsu_pkg::lsu_data_t rdata,
  input  lsu_pkg::lsu_resp_t rresp,
  input  logic               rvalid,
  output logic               rready,

  // AW, W and B
  output lsu_pkg::lsu_addr_t awaddr,
  output logic               awvalid,
  input  logic               awready,
  output lsu_pkg::lsu_data_t wdata,
  output lsu_pkg::lsu_strb_t wstrb,
  output logic               wvalid,
  input  logic               wready,
  input  lsu_pkg::lsu_resp_t bresp,
  input  logic               bvalid,
  output logic               bready,

  output logic               rack,
  output logic               wack
);

  lsu_bus_if load_bus ();
  lsu_bus_if store_bus ();

  lsu_load_unit lsu_load_unit_inst (
    .clk             (clk),
    .reset           (reset),
    .load_valid      (load_valid),
    .load_ready      (load_ready),
    .load_addr       (load_addr),
    .load_size       (load_size),
    .load_unsigned   (load_unsigned),
    .load_resp_valid (load_resp_valid),
    .load_resp_data  (load_resp_data),
    .load_resp_err   (load_resp_err),
    .bus             (load_bus.unit)
  );

  lsu_store_unit lsu_store_unit_inst (
    .clk         (clk),
    .reset       (reset),
    .store_valid (store_valid),
    .store_ready (store_ready),
    .store_addr  (store_addr),
    .store_size  (store_size),
    .store_data  (store_data),
    .store_done  (store_done),
    .store_err   (store_err),
    .bus         (store_bus.unit)
  );

  lsu_bus_arbiter lsu_bus_arbiter_inst (
    .clk       (clk),
    .reset     (reset),
    .load_bus  (load_bus.arbiter),
    .store_bus (store_bus.arbiter),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .rack      (rack),
    .wack      (wack)
  );

endmodule

//--- tb_lsu_wrap.sv
// Testbench for the LSU wrapper with an AXI memory slave model and a shadow reference
`timescale 1ns/1ps

module tb_lsu_wrap;
  import lsu_pkg::*;

  localparam int TMO    = 200;
  localparam int N_RAND = 40;
  localparam int N_PAIR = 20;

  logic      clk, reset;
  logic      load_valid, load_ready, load_unsigned, load_resp_valid, load_resp_err;
  lsu_addr_t load_addr;
  lsu_size_e load_size;
  lsu_data_t load_resp_data;
  logic      store_valid, store_ready, store_done, store_err;
  lsu_addr_t store_addr;
  lsu_size_e store_size;
  lsu_data_t store_data;
  lsu_addr_t araddr, awaddr;
  lsu_data_t rdata, wdata;
  lsu_resp_t rresp, bresp;
  lsu_strb_t wstrb;
  logic      arvalid, arready, rvalid, rready;
  logic      awvalid, awready, wvalid, wready, bvalid, bready;
  logic      rack, wack;

  lsu_data_t   mem [0:255];
  lsu_data_t   shadow [0:255];
  lsu_strb_t   last_wstrb;
  bit          txn_log [$];   // slave order with 1 for a write
  int          mismatch_count, fail_count, rd_faults, wr_faults;
  int          ar_hs, aw_hs, r_hs, b_hs, rack_cnt, wack_cnt;
  logic [31:0] stim_lfsr = 32'd93613;
  logic [31:0] rd_lfsr   = 32'd93613;
  logic [31:0] wr_lfsr   = 32'd93613;

  lsu_wrap lsu_wrap_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hB4BCD35C;
    else
      return s >> 1;
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      v = {v[30:0], state[0]};
    end
  endtask

  function automatic lsu_data_t fill_word(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, idx + 8'h3c};
  endfunction

  function automatic lsu_strb_t expected_strobe(input lsu_size_e size, input logic [1:0] offs);
    case (size)
      SIZE_BYTE: return lsu_strb_t'(4'b0001 << offs);
      SIZE_HALF: return lsu_strb_t'(4'b0011 << offs);
      default:   return 4'b1111;
    endcase
  endfunction

  // Shadow word after a store of the given size at a byte offset
  function automatic lsu_data_t merge_store(input lsu_data_t old, input logic [1:0] offs,
                                            input lsu_size_e size, input lsu_data_t data);
    lsu_data_t lanes;
    lsu_data_t res;
    lsu_strb_t strb;
    strb = expected_strobe(size, offs);
    case (size)
      SIZE_BYTE: lanes = {24'h0, data[7:0]} << {offs, 3'b000};
      SIZE_HALF: lanes = {16'h0, data[15:0]} << {offs, 3'b000};
      default:   lanes = data;
    endcase
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b])
        res[8*b +: 8] = lanes[8*b +: 8];
    end
    return res;
  endfunction

  function automatic lsu_data_t ref_load(input lsu_data_t word, input logic [1:0] offs,
                                         input lsu_size_e size, input logic uns);
    lsu_data_t sh;
    sh = word >> {offs, 3'b000};
    case (size)
      SIZE_BYTE: return uns ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
      SIZE_HALF: return uns ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
      default:   return word;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string msg);
    fail_count++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic store_access(input lsu_addr_t addr, input lsu_size_e size,
                              input lsu_data_t data, output logic err);
    int n;
    n = 0;
    while (!store_ready && n < TMO) begin
      next_cycle();
      n++;
    end
    if (!store_ready)
      report_failure("store_ready stayed low while waiting to issue a store");
    store_valid = 1'b1;
    store_addr  = addr;
    store_size  = size;
    store_data  = data;
    next_cycle();
    store_valid = 1'b0;
    n = 0;
    while (!store_done && n < TMO) begin
      next_cycle();
      n++;
    end
    if (!store_done)
      report_failure("no store_done pulse within the timeout");
    err = store_err;
  endtask

  task automatic load_access(input lsu_addr_t addr, input lsu_size_e size, input logic uns,
                             output lsu_data_t data, output logic err);
    int n;
    n = 0;
    while (!load_ready && n < TMO) begin
      next_cycle();
      n++;
    end
    if (!load_ready)
      report_failure("load_ready stayed low while waiting to issue a load");
    load_valid    = 1'b1;
    load_addr     = addr;
    load_size     = size;
    load_unsigned = uns;
    next_cycle();
    load_valid = 1'b0;
    n = 0;
    while (!load_resp_valid && n < TMO) begin
      next_cycle();
      n++;
    end
    if (!load_resp_valid)
      report_failure("no load response within the timeout");
    data = load_resp_data;
    err  = load_resp_err;
  endtask

  // Word store and word load raised in the same cycle
  task automatic paired_access(input lsu_addr_t s_addr, input lsu_data_t s_data,
                               input lsu_addr_t l_addr, output lsu_data_t l_data,
                               output logic s_err, output logic l_err);
    int n;
    bit got_s;
    bit got_l;
    n = 0;
    got_s  = 1'b0;
    got_l  = 1'b0;
    s_err  = 1'b1;
    l_err  = 1'b1;
    l_data = '0;
    while (!(store_ready && load_ready) && n < TMO) begin
      next_cycle();
      n++;
    end
    if (!(store_ready && load_ready))
      report_failure("units did not both become ready for the paired access");
    store_valid   = 1'b1;
    store_addr    = s_addr;
    store_size    = SIZE_WORD;
    store_data    = s_data;
    load_valid    = 1'b1;
    load_addr     = l_addr;
    load_size     = SIZE_WORD;
    load_unsigned = 1'b0;
    next_cycle();
    store_valid = 1'b0;
    load_valid  = 1'b0;
    n = 0;
    while (n < TMO) begin
      if (store_done) begin
        got_s = 1'b1;
        s_err = store_err;
      end
      if (load_resp_valid) begin
        got_l  = 1'b1;
        l_data = load_resp_data;
        l_err  = load_resp_err;
      end
      if (got_s && got_l)
        break;
      next_cycle();
      n++;
    end
    if (!(got_s && got_l))
      report_failure("paired load and store did not both complete");
  endtask

  initial begin : read_slave
    logic [31:0] d;
    lsu_addr_t   a;
    int          n;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = RESP_OKAY;
    forever begin
      next_cycle();
      if (arvalid) begin
        take_bits(rd_lfsr, 2, d);
        repeat (d) next_cycle();
        a = araddr;
        arready = 1'b1;
        next_cycle();
        arready = 1'b0;
        take_bits(rd_lfsr, 2, d);
        repeat (d) next_cycle();
        rdata  = mem[a[9:2]];
        rresp  = a[15] ? RESP_SLVERR : RESP_OKAY;
        rvalid = 1'b1;
        n = 0;
        while (!rready && n < TMO) begin
          next_cycle();
          n++;
        end
        if (!rready) begin
          rd_faults++;
          $display("Failure at %0t: rready stayed low while rvalid was high", $time);
        end
        next_cycle();
        rvalid = 1'b0;
      end
    end
  end

  initial begin : write_slave
    logic [31:0] d;
    lsu_addr_t   a;
    lsu_data_t   wd;
    int          n;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = RESP_OKAY;
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(8'(i));
    forever begin
      next_cycle();
      if (awvalid) begin
        take_bits(wr_lfsr, 2, d);
        repeat (d) next_cycle();
        a = awaddr;
        awready = 1'b1;
        next_cycle();
        awready = 1'b0;
        take_bits(wr_lfsr, 2, d);
        repeat (d) next_cycle();
        if (!wvalid) begin
          wr_faults++;
          $display("Failure at %0t: wvalid dropped before its handshake", $time);
        end
        wd         = wdata;
        last_wstrb = wstrb;
        wready     = 1'b1;
        next_cycle();
        wready = 1'b0;
        // Error region is never written
        if (!a[15]) begin
          for (int b = 0; b < 4; b++) begin
            if (last_wstrb[b])
              mem[a[9:2]][8*b +: 8] = wd[8*b +: 8];
          end
        end
        take_bits(wr_lfsr, 2, d);
        repeat (d) next_cycle();
        bresp  = a[15] ? RESP_SLVERR : RESP_OKAY;
        bvalid = 1'b1;
        n = 0;
        while (!bready && n < TMO) begin
          next_cycle();
          n++;
        end
        if (!bready) begin
          wr_faults++;
          $display("Failure at %0t: bready stayed low while bvalid was high", $time);
        end
        next_cycle();
        bvalid = 1'b0;
      end
    end
  end

  // Handshakes seen here complete on the next rising edge
  always @(negedge clk) begin
    if (!reset) begin
      if (arvalid && arready) begin
        ar_hs++;
        txn_log.push_back(1'b0);
      end
      if (awvalid && awready) begin
        aw_hs++;
        txn_log.push_back(1'b1);
      end
      if (rvalid && rready)
        r_hs++;
      if (bvalid && bready)
        b_hs++;
      if (rack)
        rack_cnt++;
      if (wack)
        wack_cnt++;
    end
  end

  initial begin : test_seq
    lsu_addr_t   a;
    lsu_data_t   d;
    lsu_data_t   got;
    logic [31:0] r;
    logic        e;
    logic        e2;
    lsu_size_e   sz;
    logic [7:0]  idx;
    logic [1:0]  offs;
    logic        uns;
    int          ar0;
    int          aw0;
    int          log0;
    reset         = 1'b1;
    load_valid    = 1'b0;
    load_addr     = '0;
    load_size     = SIZE_WORD;
    load_unsigned = 1'b0;
    store_valid   = 1'b0;
    store_addr    = '0;
    store_size    = SIZE_WORD;
    store_data    = '0;
    for (int i = 0; i < 256; i++)
      shadow[i] = fill_word(8'(i));
    repeat (16) @(posedge clk);
    #1;
    check_value("load_ready", 32'(load_ready), 32'd1);
    check_value("store_ready", 32'(store_ready), 32'd1);
    check_value("arvalid", 32'(arvalid), 32'd0);
    check_value("awvalid", 32'(awvalid), 32'd0);
    check_value("wvalid", 32'(wvalid), 32'd0);
    check_value("rready", 32'(rready), 32'd0);
    check_value("bready", 32'(bready), 32'd0);
    check_value("rack", 32'(rack), 32'd0);
    check_value("wack", 32'(wack), 32'd0);
    check_value("load_resp_valid", 32'(load_resp_valid), 32'd0);
    check_value("store_done", 32'(store_done), 32'd0);
    reset = 1'b0;

    // Word store then word load
    take_bits(stim_lfsr, 8, r);
    idx = r[7:0];
    take_bits(stim_lfsr, 32, r);
    d = r;
    a = {22'h0, idx, 2'b00};
    store_access(a, SIZE_WORD, d, e);
    check_value("store_err", 32'(e), 32'd0);
    shadow[idx] = d;
    load_access(a, SIZE_WORD, 1'b0, got, e);
    check_value("load_resp_err", 32'(e), 32'd0);
    check_value("load_resp_data", got, d);

    // Random byte and half traffic
    for (int i = 0; i < N_RAND; i++) begin
      take_bits(stim_lfsr, 8, r);
      idx = r[7:0];
      take_bits(stim_lfsr, 2, r);
      offs = r[1:0];
      take_bits(stim_lfsr, 1, r);
      sz = r[0] ? SIZE_HALF : SIZE_BYTE;
      if (sz == SIZE_HALF)
        offs[0] = 1'b0;
      take_bits(stim_lfsr, 32, r);
      d = r;
      take_bits(stim_lfsr, 1, r);
      uns = r[0];
      a = {22'h0, idx, offs};
      store_access(a, sz, d, e);
      check_value("store_err", 32'(e), 32'd0);
      check_value("wstrb", 32'(last_wstrb), 32'(expected_strobe(sz, offs)));
      shadow[idx] = merge_store(shadow[idx], offs, sz, d);
      load_access(a, sz, uns, got, e);
      check_value("load_resp_err", 32'(e), 32'd0);
      check_value("load_resp_data", got, ref_load(shadow[idx], offs, sz, uns));
    end

    // Same-cycle load and store pairs under round-robin grant
    for (int i = 0; i < N_PAIR; i++) begin
      take_bits(stim_lfsr, 8, r);
      idx = r[7:0];
      take_bits(stim_lfsr, 32, r);
      d = r;
      // A lone store first leaves the store unit as the last winner
      if (i % 2 == 1) begin
        store_access({22'h0, idx, 2'b00}, SIZE_WORD, ~d, e);
        check_value("store_err", 32'(e), 32'd0);
        shadow[idx] = ~d;
      end
      log0 = txn_log.size();
      paired_access({22'h0, idx, 2'b00}, d, {22'h0, idx ^ 8'h80, 2'b00}, got, e, e2);
      check_value("store_err", 32'(e), 32'd0);
      check_value("load_resp_err", 32'(e2), 32'd0);
      check_value("load_resp_data", got, shadow[idx ^ 8'h80]);
      shadow[idx] = d;
      if (txn_log.size() != log0 + 2)
        report_failure("slave did not see one read and one write for the paired access");
      else if (txn_log[log0] == txn_log[log0-1] || txn_log[log0+1] == txn_log[log0])
        report_failure("paired grant went to the unit that won the previous transaction");
    end

    // Misaligned half and word accesses stay off the bus
    ar0 = ar_hs;
    aw0 = aw_hs;
    for (int i = 1; i < 4; i++) begin
      offs = 2'(i);
      a = {22'h0, 8'h11, offs};
      load_access(a, SIZE_WORD, 1'b0, got, e);
      check_value("load_resp_err", 32'(e), 32'd1);
      store_access(a, SIZE_WORD, 32'hdeadbeef, e);
      check_value("store_err", 32'(e), 32'd1);
      if (offs[0]) begin
        load_access(a, SIZE_HALF, 1'b1, got, e);
        check_value("load_resp_err", 32'(e), 32'd1);
        store_access(a, SIZE_HALF, 32'h0000beef, e);
        check_value("store_err", 32'(e), 32'd1);
      end
    end
    repeat (4) next_cycle();
    check_value("ar handshake count", 32'(ar_hs), 32'(ar0));
    check_value("aw handshake count", 32'(aw_hs), 32'(aw0));

    // Slave error region
    store_access(32'h0000_8040, SIZE_WORD, 32'h1234_5678, e);
    check_value("store_err", 32'(e), 32'd1);
    load_access(32'h0000_8040, SIZE_WORD, 1'b0, got, e);
    check_value("load_resp_err", 32'(e), 32'd1);
    load_access(32'h0000_8043, SIZE_BYTE, 1'b0, got, e);
    check_value("load_resp_err", 32'(e), 32'd1);

    check_value("rack count", 32'(rack_cnt), 32'(r_hs));
    check_value("wack count", 32'(wack_cnt), 32'(b_hs));
    if (r_hs == 0 || b_hs == 0)
      report_failure("no read or no write response reached the slave");

    fail_count = fail_count + rd_faults + wr_faults;
    $display("Run complete: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- lsu_wrap.f
+incdir+.
lsu_pkg.sv
lsu_bus_if.sv
lsu_load_unit.sv
lsu_store_unit.sv
lsu_bus_arbiter.sv
lsu_wrap.sv
tb_lsu_wrap.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module tb_lsu_wrap \
  -Mdir "$BUILD" \
  -f lsu_wrap.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD/Vtb_lsu_wrap" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "Testbench reported errors"
  exit 1
fi

echo "Simulation finished without errors"
exit 0
